// File: bench/bench_clk_gen.sv
/*
 * Free-running clock source for the testbench.
 * Starts low and toggles every half period, default period 8.
 */

module bench_clk_gen #(
  parameter int period = 8
) (
  output logic soc_clk_o
);

  logic clk_q = 1'b0;

  // Half period low, half period high
  always #(period / 2) clk_q = ~clk_q;

  assign soc_clk_o = clk_q;

endmodule

// File: bench/board_testdata.txt
# Columns, all hex: kind src_or_value boot_mode_i boot_ovr_i boot_ovr_sel_i expected
# Kinds: 1 reset, 2 test mode, 3 strap change, 4 RTC half periods, 5 fan setting
# Reset from the button, then from debug, expected is the captured boot mode
1 0 1 2 0 1
1 0 2 3 1 3
1 1 3 0 0 3
1 1 0 2 1 2
# Test-mode bypass, expected is soc_rst_n_o right after release
2 0 0 0 0 1
2 1 0 0 0 1
# Straps changed after release keep the captured value
1 0 2 1 0 2
3 0 1 1 0 2
3 0 3 0 1 2
# RTC, six half periods of 25 cycles
4 6 0 0 0 19
# Fan, expected is 4 high cycles per step of the setting
5 0 0 0 0 0
5 f 0 0 0 3c
5 5 0 0 0 14
5 a 0 0 0 28
5 1 0 0 0 4
5 8 0 0 0 20
# Soft reset mid-run, then the timebases again
1 1 1 3 1 3
3 0 2 0 0 3
4 4 0 0 0 19
5 c 0 0 0 30
5 3 0 0 0 c

// File: bench/board_top_tb.sv
/*
 * Testbench of the board glue top level.
 * Steps are read from bench/board_testdata.txt, one per line, and cover
 * reset release, test-mode bypass, boot straps, the RTC and the fan PWM.
 * Run from the project root, normally through run_sim.sh.
 */

`include "board_defines.svh"

module board_top_tb;

  import board_pkg::*;

  // Step kinds of the data file
  localparam int kind_reset = 1;
  localparam int kind_tmode = 2;
  localparam int kind_boot  = 3;
  localparam int kind_rtc   = 4;
  localparam int kind_fan   = 5;

  localparam int drive_dly       = 1;
  localparam int init_rst_cycles = 16;
  localparam int rst_hold        = 4;
  localparam int boot_wait       = 8;
  localparam int pwm_period      = `FAN_PRESCALE * `FAN_STEPS;
  localparam int rtc_max_wait    = 2 * `RTC_HALF_PERIOD;
  // RTC and PWM phases repeat every 300 cycles
  localparam int high_max_wait   = 5 * pwm_period;

  logic       soc_clk;
  logic       rst_n;
  logic       debug_reset_i;
  logic       test_mode_i;
  boot_mode_t boot_mode_i;
  boot_mode_t boot_ovr_i;
  logic       boot_ovr_sel_i;
  fan_level_t fan_sw_i;
  logic       soc_rst_n_o;
  boot_mode_t boot_mode_o;
  logic       rtc_o;
  logic       fan_pwm_o;

  // Steps as loaded from the data file
  int kind_q[$];
  int src_q[$];
  int mode_q[$];
  int ovr_q[$];
  int sel_q[$];
  int exp_q[$];

  int n_checks    = 0;
  int n_errors    = 0;
  int n_other     = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int step_total  = 0;
  bit loaded;

  bench_clk_gen #(
    .period ( 8 )
  ) bench_clk_gen_i (
    .soc_clk_o ( soc_clk )
  );

  board_top board_top_i (
    .soc_clk        ( soc_clk        ),
    .rst_n          ( rst_n          ),
    .debug_reset_i  ( debug_reset_i  ),
    .test_mode_i    ( test_mode_i    ),
    .boot_mode_i    ( boot_mode_i    ),
    .boot_ovr_i     ( boot_ovr_i     ),
    .boot_ovr_sel_i ( boot_ovr_sel_i ),
    .fan_sw_i       ( fan_sw_i       ),
    .soc_rst_n_o    ( soc_rst_n_o    ),
    .boot_mode_o    ( boot_mode_o    ),
    .rtc_o          ( rtc_o          ),
    .fan_pwm_o      ( fan_pwm_o      )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Next drive point just after the rising edge
  task automatic step_clock();
    @(posedge soc_clk);
    #(drive_dly);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    n_checks++;
    assert (got === want) else begin
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, want, got);
      n_errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    n_other++;
  endtask

  // Source 0 is the board button, 1 the debug soft reset
  task automatic set_raw_reset(input int src, input bit active);
    if (src == 0) begin
      rst_n = ~active;
    end else begin
      debug_reset_i = active;
    end
  endtask

  // Runs until the timebases are high so a reset has something to clear.
  // A zero fan setting never goes high.
  task automatic wait_outputs_high();
    int cycles;
    cycles = 0;
    while (!(rtc_o && (fan_pwm_o || fan_sw_i == '0)) && cycles < high_max_wait) begin
      step_clock();
      cycles++;
    end
    if (!(rtc_o && (fan_pwm_o || fan_sw_i == '0))) begin
      report_failure("rtc_o and fan_pwm_o did not go high before the reset");
    end
  endtask

  // Worst-case length of a step in cycles
  function automatic int step_len(input int kind, input int src);
    case (kind)
      kind_reset: return rst_hold + 4 + high_max_wait;
      kind_tmode: return 10;
      kind_boot:  return boot_wait + 1;
      kind_rtc:   return (src + 1) * rtc_max_wait;
      kind_fan:   return 3 * pwm_period + 1;
      default:    return 1;
    endcase
  endfunction

  task automatic load_steps(output bit ok);
    int fd;
    int code;
    int kind_v;
    int src_v;
    int mode_v;
    int ovr_v;
    int sel_v;
    int exp_v;
    logic [8*256-1:0] skip_line;
    ok = 1'b0;
    fd = $fopen("bench/board_testdata.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%h %h %h %h %h %h\n", kind_v, src_v, mode_v, ovr_v, sel_v,
                       exp_v);
        if (code == 6) begin
          kind_q.push_back(kind_v);
          src_q.push_back(src_v);
          mode_q.push_back(mode_v);
          ovr_q.push_back(ovr_v);
          sel_q.push_back(sel_v);
          exp_q.push_back(exp_v);
          step_total += step_len(kind_v, src_v);
        end else if (code > 0) begin
          report_failure("malformed line in the data file");
        end else if (!$feof(fd)) begin
          // Comment line
          code = $fgets(skip_line, fd);
        end
      end
      $fclose(fd);
      ok = (kind_q.size() > 0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Step handlers
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_reset_step(input int src, input int mode, input int ovr,
                                input int sel, input int want);
    wait_outputs_high();
    boot_mode_i    = boot_mode_t'(mode);
    boot_ovr_i     = boot_mode_t'(ovr);
    boot_ovr_sel_i = (sel != 0);
    set_raw_reset(src, 1'b1);
    #(drive_dly);
    // Assertion is asynchronous and the timebases drop with it
    check_val("soc_rst_n_o", 32'(soc_rst_n_o), 0);
    check_val("rtc_o", 32'(rtc_o), 0);
    check_val("fan_pwm_o", 32'(fan_pwm_o), 0);
    repeat (rst_hold) step_clock();
    check_val("boot_mode_o", 32'(boot_mode_o), want);
    set_raw_reset(src, 1'b0);
    step_clock();
    check_val("soc_rst_n_o", 32'(soc_rst_n_o), 0);
    step_clock();
    check_val("soc_rst_n_o", 32'(soc_rst_n_o), 1);
    check_val("boot_mode_o", 32'(boot_mode_o), want);
  endtask

  task automatic run_tmode_step(input int src, input int want);
    test_mode_i = 1'b1;
    step_clock();
    set_raw_reset(src, 1'b1);
    #(drive_dly);
    check_val("soc_rst_n_o", 32'(soc_rst_n_o), 0);
    step_clock();
    step_clock();
    set_raw_reset(src, 1'b0);
    #(drive_dly);
    // Bypass releases without waiting for the synchronizer
    check_val("soc_rst_n_o", 32'(soc_rst_n_o), want);
    repeat (3) step_clock();
    test_mode_i = 1'b0;
    step_clock();
    check_val("soc_rst_n_o", 32'(soc_rst_n_o), 1);
  endtask

  task automatic run_boot_step(input int mode, input int ovr, input int sel,
                               input int want);
    boot_mode_i    = boot_mode_t'(mode);
    boot_ovr_i     = boot_mode_t'(ovr);
    boot_ovr_sel_i = (sel != 0);
    repeat (boot_wait) step_clock();
    check_val("boot_mode_o", 32'(boot_mode_o), want);
  endtask

  task automatic wait_rtc_toggle(output int cycles, output bit seen);
    logic prev;
    prev   = rtc_o;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < rtc_max_wait) begin
      step_clock();
      cycles++;
      seen = (rtc_o != prev);
    end
  endtask

  task automatic run_rtc_step(input int count, input int want);
    int  cycles;
    int  n;
    bit  seen;
    // First edge only aligns to the RTC phase
    wait_rtc_toggle(cycles, seen);
    if (!seen) begin
      report_failure("rtc_o never toggled after reset release");
    end
    n = 0;
    while (seen && n < count) begin
      wait_rtc_toggle(cycles, seen);
      if (seen) begin
        check_val("rtc_o half period", cycles, want);
      end else begin
        report_failure("rtc_o edge missing, no toggle in the allowed time");
      end
      n++;
    end
  endtask

  task automatic run_fan_step(input int setting, input int want);
    int high_cnt;
    fan_sw_i = fan_level_t'(setting);
    // New setting starts at the next period so two periods are enough
    repeat (2 * pwm_period) step_clock();
    high_cnt = 0;
    repeat (pwm_period) begin
      step_clock();
      if (fan_pwm_o) begin
        high_cnt++;
      end
    end
    check_val("fan_pwm_o high cycles", high_cnt, want);
  endtask

  task automatic run_steps();
    int i;
    for (i = 0; i < kind_q.size(); i++) begin
      case (kind_q[i])
        kind_reset: run_reset_step(src_q[i], mode_q[i], ovr_q[i], sel_q[i], exp_q[i]);
        kind_tmode: run_tmode_step(src_q[i], exp_q[i]);
        kind_boot:  run_boot_step(mode_q[i], ovr_q[i], sel_q[i], exp_q[i]);
        kind_rtc:   run_rtc_step(src_q[i], exp_q[i]);
        kind_fan:   run_fan_step(src_q[i], exp_q[i]);
        default:    report_failure($sformatf("unknown step kind %0d in step %0d",
                                             kind_q[i], i));
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge soc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: test did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    rst_n          = 1'b0;
    debug_reset_i  = 1'b0;
    test_mode_i    = 1'b0;
    boot_mode_i    = '0;
    boot_ovr_i     = '0;
    boot_ovr_sel_i = 1'b0;
    fan_sw_i       = '0;
    load_steps(loaded);
    if (!loaded) begin
      $display("Stimulus file bench/board_testdata.txt is missing or holds no steps");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      cycle_limit = step_total + 200;
      // Power-on reset from the board button
      repeat (init_rst_cycles) step_clock();
      rst_n = 1'b1;
      repeat (`RST_SYNC_STAGES + 1) step_clock();
      run_steps();
      $display("Summary: %0d checks, %0d value errors, %0d other failures",
               n_checks, n_errors, n_other);
      if (n_errors == 0 && n_other == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

// File: logic/board_defines.svh
/*
 * Timing constants for the board glue between the FPGA pins and the SoC.
 * Include it wherever the RTC divider, fan PWM or reset synchronizer
 * sizes are needed. All counts are in soc_clk cycles.
 */

`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Real-time clock
////////////////////////////////////////////////////////////////////////////

// Half period of the RTC, 50 MHz down to 1 MHz
`define RTC_HALF_PERIOD 25

////////////////////////////////////////////////////////////////////////////
// Fan PWM and reset
////////////////////////////////////////////////////////////////////////////

// Cycles per PWM step and steps per PWM period (60 cycles in total)
`define FAN_PRESCALE 4
`define FAN_STEPS 15

// Flops in the reset release synchronizer
`define RST_SYNC_STAGES 2

`endif

// File: logic/board_pkg.sv
/*
 * Shared vector types of the board glue logic.
 * Compile before any RTL or bench file that refers to these types.
 */

package board_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Board-side settings
  ////////////////////////////////////////////////////////////////////////////

  // Boot-mode code handed to the SoC
  typedef logic [1:0] boot_mode_t;

  // Fan speed from the four board switches, 0 is off and 15 is full speed
  typedef logic [3:0] fan_level_t;

  ////////////////////////////////////////////////////////////////////////////
  // Internal counters
  ////////////////////////////////////////////////////////////////////////////

  // RTC divider count
  typedef logic [15:0] rtc_cnt_t;

  // PWM step and prescale count
  typedef logic [3:0] fan_cnt_t;

endpackage

// File: logic/board_rst_ctrl.sv
/*
 * SoC reset generation and boot-mode strap capture.
 * The board button and the debug soft reset assert the SoC reset at once.
 * Release is synchronized to soc_clk, and test mode bypasses the
 * synchronizer. Boot straps are tracked during reset and frozen at release.
 */

`include "board_defines.svh"

module board_rst_ctrl (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  debug_reset_i,
  input  logic                  test_mode_i,
  input  board_pkg::boot_mode_t boot_mode_i,
  input  board_pkg::boot_mode_t boot_ovr_i,
  input  logic                  boot_ovr_sel_i,
  output logic                  soc_rst_n_o,
  output board_pkg::boot_mode_t boot_mode_o
);

  import board_pkg::*;

  // Raw reset, low while the button is pressed or debug asks for a reset
  logic raw_rst_n;

  // Release synchronizer, shifts in ones after the raw reset goes away
  logic [`RST_SYNC_STAGES-1:0] sync_q;
  logic                        sync_rst_n;

  // Boot source picked by the debug override select
  boot_mode_t boot_sel;

  ////////////////////////////////////////////////////////////////////////////
  // Reset combination and synchronization
  ////////////////////////////////////////////////////////////////////////////

  assign raw_rst_n = rst_n & ~debug_reset_i;

  // Assertion is asynchronous, release takes RST_SYNC_STAGES edges
  always_ff @(posedge soc_clk or negedge raw_rst_n) begin
    if (!raw_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign sync_rst_n = sync_q[`RST_SYNC_STAGES-1];

  // Test mode hands the raw reset straight to the SoC
  assign soc_rst_n_o = test_mode_i ? raw_rst_n : sync_rst_n;

  ////////////////////////////////////////////////////////////////////////////
  // Boot-mode straps
  ////////////////////////////////////////////////////////////////////////////

  // Debug override wins over the board straps
  assign boot_sel = boot_ovr_sel_i ? boot_ovr_i : boot_mode_i;

  // Follows the straps while the SoC is held in reset.
  // The last edge before release still samples, after that the value holds.
  always_ff @(posedge soc_clk) begin
    if (!soc_rst_n_o) begin
      boot_mode_o <= boot_sel;
    end
  end

endmodule

// File: logic/board_top.sv
/*
 * Board-level glue between the FPGA pins and the RISC-V SoC.
 * Produces the synchronized SoC reset, the captured boot mode and the
 * 1 MHz RTC for the SoC, and drives the fan PWM from the board switches.
 * soc_clk comes in already buffered from the clock wizard.
 */

module board_top (
  // Clock and board reset button
  input  logic                  soc_clk,
  input  logic                  rst_n,

  // Debug and board switch inputs
  input  logic                  debug_reset_i,
  input  logic                  test_mode_i,
  input  board_pkg::boot_mode_t boot_mode_i,
  input  board_pkg::boot_mode_t boot_ovr_i,
  input  logic                  boot_ovr_sel_i,
  input  board_pkg::fan_level_t fan_sw_i,

  // SoC side
  output logic                  soc_rst_n_o,
  output board_pkg::boot_mode_t boot_mode_o,
  output logic                  rtc_o,

  // Fan connector
  output logic                  fan_pwm_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Reset and boot mode
  ////////////////////////////////////////////////////////////////////////////

  board_rst_ctrl board_rst_ctrl_i (
    .soc_clk        ( soc_clk        ),
    .rst_n          ( rst_n          ),
    .debug_reset_i  ( debug_reset_i  ),
    .test_mode_i    ( test_mode_i    ),
    .boot_mode_i    ( boot_mode_i    ),
    .boot_ovr_i     ( boot_ovr_i     ),
    .boot_ovr_sel_i ( boot_ovr_sel_i ),
    .soc_rst_n_o    ( soc_rst_n_o    ),
    .boot_mode_o    ( boot_mode_o    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Timebases and fan
  ////////////////////////////////////////////////////////////////////////////

  // Both run from the synchronized SoC reset
  rtc_clk_div rtc_clk_div_i (
    .soc_clk ( soc_clk     ),
    .rst_n   ( soc_rst_n_o ),
    .rtc_o   ( rtc_o       )
  );

  fan_pwm_ctrl fan_pwm_ctrl_i (
    .soc_clk   ( soc_clk     ),
    .rst_n     ( soc_rst_n_o ),
    .fan_sw_i  ( fan_sw_i    ),
    .fan_pwm_o ( fan_pwm_o   )
  );

endmodule

// File: logic/fan_pwm_ctrl.sv
/*
 * Fan speed control from the four board switches.
 * A PWM period has FAN_STEPS steps of FAN_PRESCALE cycles each. The output
 * is high for as many steps as the switch setting, so 0 stops the fan and
 * 15 runs it flat out. New settings apply from the next period on.
 */

`include "board_defines.svh"

module fan_pwm_ctrl (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  board_pkg::fan_level_t fan_sw_i,
  output logic                  fan_pwm_o
);

  import board_pkg::*;

  // Last prescale count and last step of a period
  localparam fan_cnt_t pre_last  = fan_cnt_t'(`FAN_PRESCALE - 1);
  localparam fan_cnt_t step_last = fan_cnt_t'(`FAN_STEPS - 1);

  fan_cnt_t   pre_q;
  fan_cnt_t   step_q;
  fan_level_t level_q;

  logic step_tick;
  logic period_end;

  assign step_tick  = (pre_q == pre_last);
  assign period_end = step_tick && (step_q == step_last);

  ////////////////////////////////////////////////////////////////////////////
  // Step timing
  ////////////////////////////////////////////////////////////////////////////

  // Prescaler
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q <= '0;
    end else if (step_tick) begin
      pre_q <= '0;
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  // Step within the PWM period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
    end else if (period_end) begin
      step_q <= '0;
    end else if (step_tick) begin
      step_q <= step_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Duty cycle
  ////////////////////////////////////////////////////////////////////////////

  // Setting is taken once per period so a period is never cut short
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      level_q <= '0;
    end else if (period_end) begin
      level_q <= fan_sw_i;
    end
  end

  // High for the first level_q steps of every period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      fan_pwm_o <= 1'b0;
    end else begin
      fan_pwm_o <= (step_q < level_q);
    end
  end

endmodule

// File: logic/rtc_clk_div.sv
/*
 * Real-time clock divider.
 * Turns soc_clk into a square wave toggling every RTC_HALF_PERIOD cycles,
 * which gives the 1 MHz RTC input of the SoC.
 */

`include "board_defines.svh"

module rtc_clk_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  import board_pkg::*;

  // Last count of a half period
  localparam rtc_cnt_t cnt_last = rtc_cnt_t'(`RTC_HALF_PERIOD - 1);

  rtc_cnt_t cnt_q;
  logic     cnt_wrap;

  assign cnt_wrap = (cnt_q == cnt_last);

  // Half-period counter
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (cnt_wrap) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Output flips once per half period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_o <= 1'b0;
    end else if (cnt_wrap) begin
      rtc_o <= ~rtc_o;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the board glue testbench with Verilator and runs it.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module board_top_tb \
  -Mdir obj_dir -o board_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build error, see build.log"; exit 1; }

./obj_dir/board_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log && echo "Result: pass" \
  || { echo "Result: fail, see sim.log"; exit 1; }

// File: vlog.f
+incdir+logic
logic/board_pkg.sv
logic/board_rst_ctrl.sv
logic/rtc_clk_div.sv
logic/fan_pwm_ctrl.sv
logic/board_top.sv
bench/bench_clk_gen.sv
bench/board_top_tb.sv
